//--- source/pmod_macros.svh
/*
 * Shared constants for the codec subsystem: sample format, channel count,
 * gain fraction, serial timing and APB register map. Include before use.
 */
`ifndef PMOD_MACROS_SVH
`define PMOD_MACROS_SVH

// Sample format
`define PMOD_SAMPLE_W   16
`define PMOD_N_CH       4
// Gain is unsigned fixed point, unity is 1 << frac
`define PMOD_CAL_FRAC   10

// Serial timing in clk cycles
`define PMOD_BIT_DIV    2
`define PMOD_PDN_CYCLES 16

// Jack mask register, coefficient words sit below it
`define PMOD_REG_JACK   8'h20

`endif

//--- source/pmod_pkg.sv
/*
 * Types shared by the codec subsystem and its testbench, plus the
 * saturation helper used by calibration and the DSP core.
 */
`include "pmod_macros.svh"

package pmod_pkg;

    typedef logic signed [`PMOD_SAMPLE_W-1:0] sample_t;

    // ch0 is the MSB field, so it leaves the serializer first
    typedef struct packed {
        sample_t ch0;
        sample_t ch1;
        sample_t ch2;
        sample_t ch3;
    } frame_t;

    // Gain in the upper half of the register word
    typedef struct packed {
        logic [15:0] gain;
        sample_t     offset;
    } cal_coef_t;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [7:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    // Wide enough for a 17x17 signed product
    localparam int ACC_W = 2 * `PMOD_SAMPLE_W + 2;
    localparam logic signed [ACC_W-1:0] SMAX = ACC_W'(2 ** (`PMOD_SAMPLE_W - 1) - 1);
    localparam logic signed [ACC_W-1:0] SMIN = -SMAX - 1;

    // Clamp a wide intermediate into the sample range
    function automatic sample_t sat_sample(input logic signed [ACC_W-1:0] v);
        if (v > SMAX) begin
            return sample_t'(SMAX);
        end
        if (v < SMIN) begin
            return sample_t'(SMIN);
        end
        return sample_t'(v);
    endfunction

endpackage

//--- source/codec_tdm.sv
/*
 * TDM engine for an AK4619-style codec. Holds the codec in power-down after
 * reset, then runs bick/lrck, shifts the DAC frame out on sdin1 and collects
 * the ADC frame from sdout1, publishing it with a one-cycle strobe.
 */
`include "pmod_macros.svh"

module codec_tdm
    import pmod_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    output logic   pdn,
    output logic   bick,
    output logic   lrck,
    output logic   sdin1,
    input  logic   sdout1,
    input  frame_t dac_frame,
    output frame_t adc_frame,
    output logic   frame_strobe
);

    localparam int FRAME_BITS = `PMOD_N_CH * `PMOD_SAMPLE_W;
    localparam int BIT_W      = $clog2(FRAME_BITS);
    localparam int DIV_W      = (`PMOD_BIT_DIV > 2) ? $clog2(`PMOD_BIT_DIV) : 1;
    localparam int PDN_W      = $clog2(`PMOD_PDN_CYCLES);

    logic [PDN_W-1:0]      pdn_cnt;
    logic [DIV_W-1:0]      div_cnt;
    logic [BIT_W-1:0]      bit_cnt;
    logic [FRAME_BITS-1:0] dac_shift;
    logic [FRAME_BITS-1:0] adc_shift;
    logic                  bit_end;
    logic                  sample_pt;

    // Last cycle of a bit period; bick falls on the following edge
    assign bit_end   = (div_cnt == DIV_W'(`PMOD_BIT_DIV - 1));
    // Edge on which bick rises
    assign sample_pt = (div_cnt == DIV_W'(`PMOD_BIT_DIV / 2 - 1));

    // Low half then high half of each bit period
    assign bick  = (div_cnt >= DIV_W'(`PMOD_BIT_DIV / 2));
    // Slots 0-1 high, slots 2-3 low
    assign lrck  = pdn & (bit_cnt < BIT_W'(FRAME_BITS / 2));
    assign sdin1 = pdn & dac_shift[FRAME_BITS-1];

    // Power-down release
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pdn     <= 1'b0;
            pdn_cnt <= '0;
        end else if (!pdn) begin
            pdn_cnt <= pdn_cnt + 1'b1;
            if (pdn_cnt == PDN_W'(`PMOD_PDN_CYCLES - 1)) begin
                pdn <= 1'b1;
            end
        end
    end

    // ADC bits collected MSB first, ch0 lands in the top field
    always_ff @(posedge clk) begin
        if (pdn && sample_pt) begin
            adc_shift <= {adc_shift[FRAME_BITS-2:0], sdout1};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            div_cnt      <= '0;
            bit_cnt      <= '0;
            dac_shift    <= '0;
            adc_frame    <= '0;
            frame_strobe <= 1'b0;
        end else begin
            frame_strobe <= 1'b0;
            if (!pdn) begin
                // Keep the first frame ready for when the clocks start
                dac_shift <= dac_frame;
            end else if (bit_end) begin
                div_cnt <= '0;
                if (bit_cnt == BIT_W'(FRAME_BITS - 1)) begin
                    // Frame boundary
                    bit_cnt      <= '0;
                    dac_shift    <= dac_frame;
                    adc_frame    <= adc_shift;
                    frame_strobe <= 1'b1;
                end else begin
                    bit_cnt   <= bit_cnt + 1'b1;
                    dac_shift <= {dac_shift[FRAME_BITS-2:0], 1'b0};
                end
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

endmodule

//--- source/cal_regs.sv
/*
 * APB register file for calibration: eight offset/gain words (inputs then
 * outputs, four bytes apart) and the jack-present mask above them.
 */
`include "pmod_macros.svh"

module cal_regs
    import pmod_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  apb_req_t              apb_req,
    output apb_rsp_t              apb_rsp,
    output cal_coef_t             coef_in [`PMOD_N_CH],
    output cal_coef_t             coef_out [`PMOD_N_CH],
    output logic [`PMOD_N_CH-1:0] jack
);

    cal_coef_t             coef_q [2*`PMOD_N_CH];
    logic [`PMOD_N_CH-1:0] jack_q;
    logic                  access;
    logic                  hit_coef;
    logic                  hit_jack;
    logic [2:0]            idx;

    // Access phase of a transfer
    assign access   = apb_req.psel & apb_req.penable;
    assign hit_coef = (apb_req.paddr < `PMOD_REG_JACK);
    assign hit_jack = (apb_req.paddr == `PMOD_REG_JACK);
    // Word index, byte lanes ignored
    assign idx      = apb_req.paddr[4:2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            // Unity gain, no offset, all jacks present
            for (int i = 0; i < 2 * `PMOD_N_CH; i++) begin
                coef_q[i].gain   <= 16'(1 << `PMOD_CAL_FRAC);
                coef_q[i].offset <= '0;
            end
            jack_q <= '1;
        end else if (access && apb_req.pwrite) begin
            if (hit_coef) begin
                coef_q[idx] <= cal_coef_t'(apb_req.pwdata);
            end else if (hit_jack) begin
                jack_q <= apb_req.pwdata[`PMOD_N_CH-1:0];
            end
        end
    end

    // Zero wait states; error only for the unmapped range
    always_comb begin
        apb_rsp.pready  = 1'b1;
        apb_rsp.pslverr = access & ~(hit_coef | hit_jack);
        apb_rsp.prdata  = '0;
        if (hit_coef) begin
            apb_rsp.prdata = coef_q[idx];
        end else if (hit_jack) begin
            apb_rsp.prdata = 32'(jack_q);
        end
    end

    for (genvar i = 0; i < `PMOD_N_CH; i++) begin : g_coef
        assign coef_in[i]  = coef_q[i];
        assign coef_out[i] = coef_q[`PMOD_N_CH + i];
    end

    assign jack = jack_q;

endmodule

//--- source/cal_pipe.sv
/*
 * Per-frame calibration: applies offset and gain to the ADC frame (after
 * undoing the front-end inversion) and to the core output, one channel per
 * cycle through a shared multiplier. Unplugged inputs read as zero.
 */
`include "pmod_macros.svh"

module cal_pipe
    import pmod_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  frame_strobe,
    input  frame_t                adc_frame,
    input  frame_t                core_frame,
    input  cal_coef_t             coef_in [`PMOD_N_CH],
    input  cal_coef_t             coef_out [`PMOD_N_CH],
    input  logic [`PMOD_N_CH-1:0] jack,
    output frame_t                cal_in_frame,
    output logic                  cal_valid,
    output frame_t                dac_frame
);

    localparam int N_STEP = 2 * `PMOD_N_CH;
    localparam int STEP_W = $clog2(N_STEP);

    sample_t                  src [N_STEP];
    sample_t                  res_q [N_STEP];
    logic [STEP_W-1:0]        step;
    logic                     busy;
    cal_coef_t                coef_sel;
    logic signed [16:0]       sum;
    logic signed [16:0]       gain_s;
    logic signed [ACC_W-1:0]  prod;
    sample_t                  cal_res;
    logic                     jack_ok;

    // Upper half of the sequence handles the outputs
    assign coef_sel = step[2] ? coef_out[step[1:0]] : coef_in[step[1:0]];
    assign sum      = src[step] + coef_sel.offset;
    assign gain_s   = signed'({1'b0, coef_sel.gain});
    assign prod     = sum * gain_s;
    // Output channels ignore the jack mask
    assign jack_ok  = step[2] | jack[step[1:0]];
    assign cal_res  = jack_ok ? sat_sample(prod >>> `PMOD_CAL_FRAC) : '0;

    // Snapshot both directions at the frame strobe
    always_ff @(posedge clk) begin
        if (frame_strobe) begin
            // Front end inverts the inputs
            src[0] <= ~adc_frame.ch0;
            src[1] <= ~adc_frame.ch1;
            src[2] <= ~adc_frame.ch2;
            src[3] <= ~adc_frame.ch3;
            // Core result from the previous frame
            src[4] <= core_frame.ch0;
            src[5] <= core_frame.ch1;
            src[6] <= core_frame.ch2;
            src[7] <= core_frame.ch3;
        end
        if (busy) begin
            res_q[step] <= cal_res;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy         <= 1'b0;
            step         <= '0;
            cal_valid    <= 1'b0;
            cal_in_frame <= '0;
            dac_frame    <= '0;
        end else begin
            cal_valid <= 1'b0;
            if (frame_strobe) begin
                busy <= 1'b1;
                step <= '0;
            end else if (busy) begin
                step <= step + 1'b1;
                if (step == STEP_W'(`PMOD_N_CH - 1)) begin
                    // Inputs done, hand them to the core
                    cal_in_frame <= '{res_q[0], res_q[1], res_q[2], cal_res};
                    cal_valid    <= 1'b1;
                end
                if (step == STEP_W'(N_STEP - 1)) begin
                    dac_frame <= '{res_q[4], res_q[5], res_q[6], cal_res};
                    busy      <= 1'b0;
                end
            end
        end
    end

endmodule

//--- source/vca_core.sv
/*
 * DSP core: voltage-controlled amplifier on channel 0 with channel 1 as the
 * control input, channels 1-3 passed through. Updates once per frame.
 */
`include "pmod_macros.svh"

module vca_core
    import pmod_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   cal_valid,
    input  frame_t cal_in_frame,
    output frame_t core_frame
);

    logic signed [ACC_W-1:0] prod;
    sample_t                 vca_out;

    // Signal times control, Q15 scaling
    assign prod    = cal_in_frame.ch0 * cal_in_frame.ch1;
    // Only full negative times full negative overflows
    assign vca_out = sat_sample(prod >>> (`PMOD_SAMPLE_W - 1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            core_frame <= '0;
        end else if (cal_valid) begin
            core_frame.ch0 <= vca_out;
            // Pass-through channels
            core_frame.ch1 <= cal_in_frame.ch1;
            core_frame.ch2 <= cal_in_frame.ch2;
            core_frame.ch3 <= cal_in_frame.ch3;
        end
    end

endmodule

//--- source/pmod_top.sv
/*
 * Top level of the codec subsystem: TDM engine, calibration, VCA core and
 * the APB register block. The host programs calibration over APB.
 */
`include "pmod_macros.svh"

module pmod_top
    import pmod_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    output logic     pdn,
    output logic     bick,
    output logic     lrck,
    output logic     sdin1,
    input  logic     sdout1,
    input  apb_req_t apb_req,
    output apb_rsp_t apb_rsp
);

    // Raw frames to and from the codec
    frame_t                adc_frame;
    frame_t                dac_frame;
    logic                  frame_strobe;
    // Calibrated inputs and core output
    frame_t                cal_in_frame;
    logic                  cal_valid;
    frame_t                core_frame;
    // Register contents
    cal_coef_t             coef_in [`PMOD_N_CH];
    cal_coef_t             coef_out [`PMOD_N_CH];
    logic [`PMOD_N_CH-1:0] jack;

    codec_tdm u_codec (
        .clk          (clk),
        .rst_n        (rst_n),
        .pdn          (pdn),
        .bick         (bick),
        .lrck         (lrck),
        .sdin1        (sdin1),
        .sdout1       (sdout1),
        .dac_frame    (dac_frame),
        .adc_frame    (adc_frame),
        .frame_strobe (frame_strobe)
    );

    cal_regs u_regs (
        .clk      (clk),
        .rst_n    (rst_n),
        .apb_req  (apb_req),
        .apb_rsp  (apb_rsp),
        .coef_in  (coef_in),
        .coef_out (coef_out),
        .jack     (jack)
    );

    // Core output returns through the output half of calibration
    cal_pipe u_cal (
        .clk          (clk),
        .rst_n        (rst_n),
        .frame_strobe (frame_strobe),
        .adc_frame    (adc_frame),
        .core_frame   (core_frame),
        .coef_in      (coef_in),
        .coef_out     (coef_out),
        .jack         (jack),
        .cal_in_frame (cal_in_frame),
        .cal_valid    (cal_valid),
        .dac_frame    (dac_frame)
    );

    vca_core u_core (
        .clk          (clk),
        .rst_n        (rst_n),
        .cal_valid    (cal_valid),
        .cal_in_frame (cal_in_frame),
        .core_frame   (core_frame)
    );

endmodule

//--- verif/tb_pmod_top.sv
/*
 * Testbench for the codec subsystem top level. Plays a bit-level codec on
 * the TDM pins, programs calibration over APB from an LFSR and compares
 * every DAC frame with a reference model of calibration and the VCA core.
 */
`include "pmod_macros.svh"

module tb_pmod_top
    import pmod_pkg::*;
();

    localparam int NF            = 64;
    localparam int PDN_TIMEOUT   = 64;
    localparam int FRAME_TIMEOUT = 3 * 128;
    localparam int APB_TIMEOUT   = 8;
    localparam logic [31:0] UNITY = 32'h0400_0000;

    logic     clk = 1'b0;
    logic     rst_n;
    logic     pdn;
    logic     bick;
    logic     lrck;
    logic     sdin1;
    logic     sdout1;
    apb_req_t apb_req;
    apb_rsp_t apb_rsp;

    // Random source and result bookkeeping
    logic [15:0] lfsr_q = 16'd13228;
    int          checks = 0;
    int          errors = 0;
    int          timeouts = 0;
    int          sat_hi = 0;
    int          sat_lo = 0;

    // Frames sent to and received from the codec model
    logic [63:0] adc_frames [NF];
    logic [63:0] dac_rcvd [$];
    logic [63:0] rx_shift;
    int          bit_idx;
    int          tx_idx;
    // lrck half-frame tracking
    int          run_len;
    logic        run_lvl;
    int          lrck_runs;
    logic        sdin1_prev = 1'b0;
    int          sdin1_changes = 0;

    // Reference copies of the register block
    logic [31:0] mdl_coef [8];
    logic [3:0]  mdl_jack;

    pmod_top DUT (
        .clk     (clk),
        .rst_n   (rst_n),
        .pdn     (pdn),
        .bick    (bick),
        .lrck    (lrck),
        .sdin1   (sdin1),
        .sdout1  (sdout1),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp)
    );

    always #5 clk = ~clk;

    // 16-bit Fibonacci LFSR with taps x^16 + x^14 + x^13 + x^11 + 1 stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        int          i;
        v = '0;
        for (i = 0; i < n; i++) begin
            fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
            lfsr_q = {lfsr_q[14:0], fb};
            v      = {v[30:0], fb};
        end
        return v;
    endfunction

    task automatic finish_run();
        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    endtask

    task automatic timeout_fail(input string what);
        timeouts++;
        $display("ERROR: timed out at t=%0t waiting for %s", $time, what);
        finish_run();
    endtask

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // Outputs that must stay low until the codec is released
    task automatic check_idle();
        check_val("pdn", pdn, 0);
        check_val("bick", bick, 0);
        check_val("lrck", lrck, 0);
        check_val("sdin1", sdin1, 0);
        check_val("pslverr", apb_rsp.pslverr, 0);
    endtask

    // Clamp to the 16-bit range and count which limit was hit
    task automatic saturate(input longint v, output logic [15:0] r);
        if (v > 32767) begin
            r = 16'h7FFF;
            sat_hi++;
        end else if (v < -32768) begin
            r = 16'h8000;
            sat_lo++;
        end else begin
            r = v[15:0];
        end
    endtask

    // Offset first, then Q10 gain with an arithmetic shift back
    task automatic cal_apply(input logic [15:0] s, input logic [31:0] coef,
                             output logic [15:0] r);
        longint sum;
        longint prod;
        sum  = longint'($signed(s)) + longint'($signed(coef[15:0]));
        prod = sum * longint'(coef[31:16]);
        saturate(prod >>> `PMOD_CAL_FRAC, r);
    endtask

    // Full path of one ADC frame to the DAC frame it produces
    task automatic model_frame(input logic [63:0] adc, output logic [63:0] dac);
        logic [15:0] cin [4];
        logic [15:0] core [4];
        logic [15:0] r;
        longint      prod;
        int          c;
        for (c = 0; c < 4; c++) begin
            if (mdl_jack[c]) begin
                // Front end delivers inverted samples
                cal_apply(~adc[63-16*c -: 16], mdl_coef[c], cin[c]);
            end else begin
                cin[c] = '0;
            end
        end
        // VCA scales ch0 by ch1 in Q15
        prod = longint'($signed(cin[0])) * longint'($signed(cin[1]));
        saturate(prod >>> (`PMOD_SAMPLE_W - 1), core[0]);
        for (c = 1; c < 4; c++) begin
            core[c] = cin[c];
        end
        dac = '0;
        for (c = 0; c < 4; c++) begin
            cal_apply(core[c], mdl_coef[4 + c], r);
            dac[63-16*c -: 16] = r;
        end
    endtask

    // Codec model acting on the edge that ends the bick-high half of a bit
    always @(posedge clk) begin
        if (!rst_n) begin
            bit_idx   = 0;
            tx_idx    = 0;
            run_len   = 0;
            run_lvl   = 1'b1;
            lrck_runs = 0;
            sdout1 <= adc_frames[0][63];
        end else if (bick === 1'b1) begin
            rx_shift = {rx_shift[62:0], sdin1};
            // Each lrck level must last exactly two slots
            if (lrck === run_lvl) begin
                run_len++;
            end else begin
                check_val("lrck run length in bits", run_len, 32);
                lrck_runs++;
                run_lvl = lrck;
                run_len = 1;
            end
            if (bit_idx == 63) begin
                dac_rcvd.push_back(rx_shift);
                bit_idx = 0;
                tx_idx++;
            end else begin
                bit_idx++;
            end
            // Next ADC bit held through the following bick-low half
            sdout1 <= adc_frames[tx_idx % NF][63 - bit_idx];
        end
    end

    // sdin1 may only move at the start of a bick-low half
    always @(posedge clk) begin
        if (rst_n === 1'b1 && sdin1 !== sdin1_prev) begin
            sdin1_changes++;
            assert (bick === 1'b0) else begin
                errors++;
                $display("ERROR: sdin1 changed while bick was high at t=%0t", $time);
            end
        end
        sdin1_prev = sdin1;
    end

    task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
        int t;
        @(posedge clk);
        apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
        @(posedge clk);
        apb_req.penable <= 1'b1;
        // Access cycle ends on the first edge with pready high
        t = 0;
        @(posedge clk);
        // No wait states, so pready is high in the first access cycle
        check_val("pready", apb_rsp.pready, 1'b1);
        while (apb_rsp.pready !== 1'b1 && t < APB_TIMEOUT) begin
            @(posedge clk);
            t++;
        end
        if (apb_rsp.pready !== 1'b1) begin
            timeout_fail("APB pready");
        end
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        apb_req <= '0;
    endtask

    task automatic reg_write(input logic [7:0] addr, input logic [31:0] data);
        logic [31:0] rd;
        logic        err;
        apb_xfer(1'b1, addr, data, rd, err);
        check_val($sformatf("pslverr on write to %h", addr), err, addr > `PMOD_REG_JACK);
        if (addr < `PMOD_REG_JACK) begin
            mdl_coef[addr[4:2]] = data;
        end else if (addr == `PMOD_REG_JACK) begin
            mdl_jack = data[3:0];
        end
    endtask

    task automatic reg_check(input logic [7:0] addr);
        logic [31:0] rd;
        logic [31:0] exp;
        logic        err;
        apb_xfer(1'b0, addr, '0, rd, err);
        check_val($sformatf("pslverr on read of %h", addr), err, addr > `PMOD_REG_JACK);
        exp = (addr == `PMOD_REG_JACK) ? {28'b0, mdl_jack} : mdl_coef[addr[4:2]];
        if (addr <= `PMOD_REG_JACK) begin
            check_val($sformatf("prdata at %h", addr), rd, exp);
        end
    endtask

    task automatic program_coef(input int idx, input logic [15:0] gain,
                                input logic [15:0] offset);
        reg_write(8'(4 * idx), {gain, offset});
    endtask

    task automatic set_identity();
        int i;
        for (i = 0; i < 8; i++) begin
            reg_write(8'(4 * i), UNITY);
        end
    endtask

    // Returns the index of the next complete DAC frame
    task automatic next_dac(output int j);
        int n0;
        int t;
        n0 = dac_rcvd.size();
        t  = 0;
        while (dac_rcvd.size() == n0 && t < FRAME_TIMEOUT) begin
            @(posedge clk);
            t++;
        end
        if (dac_rcvd.size() == n0) begin
            timeout_fail("a DAC frame");
        end
        j = dac_rcvd.size() - 1;
    endtask

    task automatic wait_frames(input int n);
        int k;
        int j;
        for (k = 0; k < n; k++) begin
            next_dac(j);
        end
    endtask

    // Wire frame j is latched as ADC frame j-1 comes out and so carries ADC frame j-3
    task automatic check_frames(input int n);
        logic [63:0] exp;
        logic [63:0] got;
        int          k;
        int          j;
        int          c;
        for (k = 0; k < n; k++) begin
            next_dac(j);
            model_frame(adc_frames[(j - 3) % NF], exp);
            got = dac_rcvd[j];
            for (c = 0; c < 4; c++) begin
                check_val($sformatf("dac frame %0d ch%0d", j, c),
                          got[63-16*c -: 16], exp[63-16*c -: 16]);
            end
        end
    endtask

    task automatic wait_pdn();
        int t;
        t = 0;
        @(posedge clk);
        while (pdn !== 1'b1 && t < PDN_TIMEOUT) begin
            check_idle();
            @(posedge clk);
            t++;
        end
        if (pdn !== 1'b1) begin
            timeout_fail("pdn to rise after reset");
        end
    endtask

    initial begin
        logic [31:0] r0;
        logic [31:0] r1;
        logic [7:0]  bad;
        logic [3:0]  mask;
        int          i;
        rst_n   = 1'b0;
        sdout1  = 1'b0;
        apb_req = '0;
        for (i = 0; i < NF; i++) begin
            r0 = rand_bits(32);
            r1 = rand_bits(32);
            adc_frames[i] = {r0, r1};
        end
        // Register reset values
        for (i = 0; i < 8; i++) begin
            mdl_coef[i] = UNITY;
        end
        mdl_jack = 4'hF;

        // Reset spans four edges and the first one loads the flops
        @(posedge clk);
        repeat (3) begin
            @(posedge clk);
            check_idle();
        end
        rst_n <= 1'b1;
        wait_pdn();

        // Register read-back
        for (i = 0; i < 9; i++) begin
            reg_write(8'(4 * i), rand_bits(32));
        end
        for (i = 0; i < 9; i++) begin
            reg_check(8'(4 * i));
        end
        // Unmapped range 0x21..0xFF
        bad = 8'h21 + 8'(rand_bits(8) % 32'hDF);
        reg_write(bad, rand_bits(32));
        reg_check(bad);
        for (i = 0; i < 9; i++) begin
            reg_check(8'(4 * i));
        end

        // Identity calibration with all jacks present
        set_identity();
        reg_write(`PMOD_REG_JACK, 32'hF);
        wait_frames(4);
        check_frames(4);

        // Gains from 0.5 to 1.5 with small signed offsets
        for (i = 0; i < 8; i++) begin
            r0 = rand_bits(12);
            program_coef(i, 16'd512 + 16'(rand_bits(10)), {{4{r0[11]}}, r0[11:0]});
        end
        wait_frames(4);
        check_frames(4);

        // Gains of x8 and more drive most results into the limits
        for (i = 0; i < 8; i++) begin
            r0 = rand_bits(12);
            program_coef(i, 16'h2000 + 16'(rand_bits(13)), {{4{r0[11]}}, r0[11:0]});
        end
        wait_frames(4);
        sat_hi = 0;
        sat_lo = 0;
        check_frames(3);
        assert (sat_hi > 0 && sat_lo > 0) else begin
            errors++;
            $display("ERROR: large gains did not reach both saturation limits");
        end

        // At least one jack unplugged
        set_identity();
        mask = 4'(rand_bits(4));
        if (&mask) begin
            mask[2] = 1'b0;
        end
        reg_write(`PMOD_REG_JACK, {28'b0, mask});
        wait_frames(4);
        check_frames(4);

        // Frame structure monitors must have seen enough traffic
        assert (lrck_runs >= 40 && sdin1_changes > 0) else begin
            errors++;
            $display("ERROR: too few lrck half frames or sdin1 changes were observed");
        end
        finish_run();
    end

endmodule

//--- vlog.f
+incdir+source
source/pmod_pkg.sv
source/codec_tdm.sv
source/cal_regs.sv
source/cal_pipe.sv
source/vca_core.sv
source/pmod_top.sv
verif/tb_pmod_top.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_pmod_top
FILELIST  = vlog.f
OBJ_DIR   = obj_dir

SIM     = $(OBJ_DIR)/V$(TOP)
SOURCES = $(shell grep -v '^+' $(FILELIST))
HEADERS = $(wildcard source/*.svh)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(FILELIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx '=== PASS ==='

clean:
	rm -rf $(OBJ_DIR)
